// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tcdm_atomic_xbar_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for a pass"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
hdl/tcdm_pkg.sv
hdl/tcdm_req_decode.sv
hdl/tcdm_bank_arbiter.sv
hdl/amo_shim.sv
hdl/tcdm_resp_route.sv
hdl/tcdm_atomic_xbar.sv
tests/tcdm_atomic_xbar_props.sv
tests/tcdm_atomic_xbar_tb.sv

// ==== hdl/amo_shim.sv ====
module amo_shim (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              valid_i,
    input  tcdm_pkg::bank_req_t               bank_req_i,
    output logic                              ready_o,
    output logic [tcdm_pkg::DATA_WIDTH-1:0]   rdata_o,
    output logic                              sram_req_o,
    output tcdm_pkg::sram_req_t               sram_o,
    input  logic [tcdm_pkg::DATA_WIDTH-1:0]   sram_rdata_i
);

    import tcdm_pkg::*;

    typedef enum logic {
        IDLE,
        WRITEBACK
    } state_e;

    state_e                     state_q, state_d;
    amo_op_e                    amo_q;
    logic [BANK_ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0]      operand_q;
    logic [DATA_WIDTH-1:0]      amo_result;
    logic                       is_amo;

    assign is_amo = (bank_req_i.amo != AMO_NONE);

    // New memory value from the old word and the stored operand
    always_comb begin
        case (amo_q)
            AMO_SWAP: amo_result = operand_q;
            AMO_ADD:  amo_result = sram_rdata_i + operand_q;
            AMO_AND:  amo_result = sram_rdata_i & operand_q;
            AMO_OR:   amo_result = sram_rdata_i | operand_q;
            AMO_XOR:  amo_result = sram_rdata_i ^ operand_q;
            AMO_MAX: begin
                amo_result = ($signed(sram_rdata_i) > $signed(operand_q)) ?
                             sram_rdata_i : operand_q;
            end
            AMO_MIN: begin
                amo_result = ($signed(sram_rdata_i) < $signed(operand_q)) ?
                             sram_rdata_i : operand_q;
            end
            AMO_MAXU: amo_result = (sram_rdata_i > operand_q) ? sram_rdata_i : operand_q;
            AMO_MINU: amo_result = (sram_rdata_i < operand_q) ? sram_rdata_i : operand_q;
            default:  amo_result = sram_rdata_i;
        endcase
    end

    always_comb begin
        state_d      = state_q;
        ready_o      = 1'b1;
        sram_req_o   = 1'b0;
        sram_o.addr  = bank_req_i.addr;
        sram_o.we    = bank_req_i.write;
        sram_o.wdata = bank_req_i.wdata;
        sram_o.be    = bank_req_i.be;
        case (state_q)
            IDLE: begin
                sram_req_o = valid_i;
                if (valid_i && is_amo) begin
                    // Read the old word first, write it back next cycle
                    sram_o.we = 1'b0;
                    state_d   = WRITEBACK;
                end
            end
            WRITEBACK: begin
                ready_o      = 1'b0;
                sram_req_o   = 1'b1;
                sram_o.addr  = addr_q;
                sram_o.we    = 1'b1;
                sram_o.wdata = amo_result;
                sram_o.be    = '1;
                state_d      = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Atomic operands captured in the read cycle
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && valid_i && is_amo) begin
            amo_q     <= bank_req_i.amo;
            addr_q    <= bank_req_i.addr;
            operand_q <= bank_req_i.wdata;
        end
    end

    // Read data from the previous cycle, old value for atomics
    assign rdata_o = sram_rdata_i;

endmodule

// ==== hdl/tcdm_atomic_xbar.sv ====
module tcdm_atomic_xbar #(
    parameter int unsigned NB_PORTS = 4,
    parameter int unsigned NB_BANKS = 2
) (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    // Requester ports
    input  logic [NB_PORTS-1:0]                             req_i,
    input  tcdm_pkg::port_req_t [NB_PORTS-1:0]              port_req_i,
    output logic [NB_PORTS-1:0]                             gnt_o,
    output logic [NB_PORTS-1:0]                             rvalid_o,
    output logic [NB_PORTS-1:0][tcdm_pkg::DATA_WIDTH-1:0]   rdata_o,
    // SRAM banks
    output logic [NB_BANKS-1:0]                             sram_req_o,
    output tcdm_pkg::sram_req_t [NB_BANKS-1:0]              sram_o,
    input  logic [NB_BANKS-1:0][tcdm_pkg::DATA_WIDTH-1:0]   sram_rdata_i
);

    import tcdm_pkg::*;

    localparam int unsigned IDX_W = (NB_PORTS > 1) ? $clog2(NB_PORTS) : 1;

    logic [NB_PORTS-1:0][NB_BANKS-1:0] bank_sel;
    bank_req_t [NB_PORTS-1:0]          port_bank_req;
    logic [NB_BANKS-1:0][NB_PORTS-1:0] bank_gnt;
    logic [NB_BANKS-1:0]               bank_valid;
    logic [NB_BANKS-1:0]               shim_ready;
    bank_req_t [NB_BANKS-1:0]          win_req;
    logic [NB_BANKS-1:0][IDX_W-1:0]    winner;
    logic [NB_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata;

    tcdm_req_decode #(
        .NB_PORTS (NB_PORTS),
        .NB_BANKS (NB_BANKS)
    ) i_req_decode (
        .req_i      (req_i),
        .port_req_i (port_req_i),
        .bank_sel_o (bank_sel),
        .bank_req_o (port_bank_req)
    );

    for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
        logic [NB_PORTS-1:0] bank_req;

        // Column of request bits aimed at this bank
        for (genvar p = 0; p < NB_PORTS; p++) begin : gen_col
            assign bank_req[p] = bank_sel[p][b];
        end

        tcdm_bank_arbiter #(
            .NB_PORTS (NB_PORTS)
        ) i_arbiter (
            .clk_i      (clk_i),
            .rst_i      (rst_i),
            .req_i      (bank_req),
            .bank_req_i (port_bank_req),
            .ready_i    (shim_ready[b]),
            .gnt_o      (bank_gnt[b]),
            .valid_o    (bank_valid[b]),
            .bank_req_o (win_req[b]),
            .winner_o   (winner[b])
        );

        amo_shim i_amo_shim (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .valid_i      (bank_valid[b]),
            .bank_req_i   (win_req[b]),
            .ready_o      (shim_ready[b]),
            .rdata_o      (bank_rdata[b]),
            .sram_req_o   (sram_req_o[b]),
            .sram_o       (sram_o[b]),
            .sram_rdata_i (sram_rdata_i[b])
        );
    end

    // A port is granted when any bank picks it
    always_comb begin
        gnt_o = '0;
        for (int unsigned b = 0; b < NB_BANKS; b++) begin
            gnt_o = gnt_o | bank_gnt[b];
        end
    end

    tcdm_resp_route #(
        .NB_PORTS (NB_PORTS),
        .NB_BANKS (NB_BANKS)
    ) i_resp_route (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .granted_i    (bank_valid),
        .winner_i     (winner),
        .bank_rdata_i (bank_rdata),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o)
    );

endmodule

// ==== hdl/tcdm_bank_arbiter.sv ====
module tcdm_bank_arbiter #(
    parameter int unsigned NB_PORTS = 4,
    localparam int unsigned IDX_W   = (NB_PORTS > 1) ? $clog2(NB_PORTS) : 1
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [NB_PORTS-1:0]                 req_i,
    input  tcdm_pkg::bank_req_t [NB_PORTS-1:0]  bank_req_i,
    input  logic                                ready_i,
    output logic [NB_PORTS-1:0]                 gnt_o,
    output logic                                valid_o,
    output tcdm_pkg::bank_req_t                 bank_req_o,
    output logic [IDX_W-1:0]                    winner_o
);

    import tcdm_pkg::*;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] winner;
    logic             found;

    // First requesting port at or after the pointer, wrapping around
    always_comb begin
        int unsigned cand;
        found  = 1'b0;
        winner = '0;
        cand   = 0;
        for (int unsigned i = 0; i < NB_PORTS; i++) begin
            cand = (int'(ptr_q) + i) % NB_PORTS;
            if (!found && req_i[cand]) begin
                found  = 1'b1;
                winner = IDX_W'(cand);
            end
        end
    end

    assign valid_o    = found & ready_i;
    assign winner_o   = winner;
    assign bank_req_o = bank_req_i[winner];

    always_comb begin
        gnt_o = '0;
        if (valid_o) begin
            gnt_o[winner] = 1'b1;
        end
    end

    // Move the pointer past the port that just won
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else if (valid_o) begin
            if (winner == IDX_W'(NB_PORTS - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= winner + IDX_W'(1);
            end
        end
    end

endmodule

// ==== hdl/tcdm_pkg.sv ====
package tcdm_pkg;

    // Bus widths
    localparam int unsigned DATA_WIDTH      = 32;
    localparam int unsigned BE_WIDTH        = DATA_WIDTH / 8;
    localparam int unsigned ADDR_WIDTH      = 32;
    localparam int unsigned BANK_ADDR_WIDTH = 10;

    // RISC-V AMO funct5 codes, carried in atop[4:0]
    typedef enum logic [4:0] {
        ATOP_ADD  = 5'b00000,
        ATOP_SWAP = 5'b00001,
        ATOP_LR   = 5'b00010,
        ATOP_SC   = 5'b00011,
        ATOP_XOR  = 5'b00100,
        ATOP_OR   = 5'b01000,
        ATOP_AND  = 5'b01100,
        ATOP_MIN  = 5'b10000,
        ATOP_MAX  = 5'b10100,
        ATOP_MINU = 5'b11000,
        ATOP_MAXU = 5'b11100
    } atop_funct_e;

    // Operations carried out by the AMO shim
    typedef enum logic [3:0] {
        AMO_NONE = 4'h0,
        AMO_SWAP = 4'h1,
        AMO_ADD  = 4'h2,
        AMO_AND  = 4'h3,
        AMO_OR   = 4'h4,
        AMO_XOR  = 4'h5,
        AMO_MAX  = 4'h6,
        AMO_MAXU = 4'h7,
        AMO_MIN  = 4'h8,
        AMO_MINU = 4'h9
    } amo_op_e;

    // Raw request as it arrives on a port, wen_n low means write
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  wen_n;
        logic [BE_WIDTH-1:0]   be;
        logic [5:0]            atop;
    } port_req_t;

    // Request after decode, addressed inside one bank
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]      wdata;
        logic                       write;
        logic [BE_WIDTH-1:0]        be;
        amo_op_e                    amo;
    } bank_req_t;

    // SRAM port of one bank
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic                       we;
        logic [DATA_WIDTH-1:0]      wdata;
        logic [BE_WIDTH-1:0]        be;
    } sram_req_t;

endpackage

// ==== hdl/tcdm_req_decode.sv ====
module tcdm_req_decode #(
    parameter int unsigned NB_PORTS = 4,
    parameter int unsigned NB_BANKS = 2
) (
    input  logic [NB_PORTS-1:0]                       req_i,
    input  tcdm_pkg::port_req_t [NB_PORTS-1:0]        port_req_i,
    output logic [NB_PORTS-1:0][NB_BANKS-1:0]         bank_sel_o,
    output tcdm_pkg::bank_req_t [NB_PORTS-1:0]        bank_req_o
);

    import tcdm_pkg::*;

    localparam int unsigned BYTE_OFF   = $clog2(BE_WIDTH);
    localparam int unsigned BANK_IDX_W = $clog2(NB_BANKS);

    logic [NB_PORTS-1:0][BANK_IDX_W-1:0] bank_idx;
    amo_op_e [NB_PORTS-1:0]              amo;

    for (genvar p = 0; p < NB_PORTS; p++) begin : gen_port
        // Word interleaving: bank index sits just above the byte offset
        assign bank_idx[p] = port_req_i[p].addr[BYTE_OFF +: BANK_IDX_W];

        always_comb begin
            bank_sel_o[p] = '0;
            bank_sel_o[p][bank_idx[p]] = req_i[p];
        end

        // Map atop to a shim operation, LR and SC are not supported here
        always_comb begin
            amo[p] = AMO_NONE;
            if (port_req_i[p].atop[5]) begin
                case (atop_funct_e'(port_req_i[p].atop[4:0]))
                    ATOP_ADD:  amo[p] = AMO_ADD;
                    ATOP_SWAP: amo[p] = AMO_SWAP;
                    ATOP_XOR:  amo[p] = AMO_XOR;
                    ATOP_OR:   amo[p] = AMO_OR;
                    ATOP_AND:  amo[p] = AMO_AND;
                    ATOP_MIN:  amo[p] = AMO_MIN;
                    ATOP_MAX:  amo[p] = AMO_MAX;
                    ATOP_MINU: amo[p] = AMO_MINU;
                    ATOP_MAXU: amo[p] = AMO_MAXU;
                    default:   amo[p] = AMO_NONE;
                endcase
            end
        end

        always_comb begin
            bank_req_o[p].addr  = port_req_i[p].addr[BYTE_OFF+BANK_IDX_W +: BANK_ADDR_WIDTH];
            bank_req_o[p].wdata = port_req_i[p].wdata;
            bank_req_o[p].amo   = amo[p];
            if (amo[p] != AMO_NONE) begin
                // Atomics always update a full word
                bank_req_o[p].write = 1'b1;
                bank_req_o[p].be    = '1;
            end else begin
                bank_req_o[p].write = ~port_req_i[p].wen_n;
                bank_req_o[p].be    = port_req_i[p].be;
            end
        end
    end

endmodule

// ==== hdl/tcdm_resp_route.sv ====
module tcdm_resp_route #(
    parameter int unsigned NB_PORTS = 4,
    parameter int unsigned NB_BANKS = 2,
    localparam int unsigned IDX_W   = (NB_PORTS > 1) ? $clog2(NB_PORTS) : 1
) (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    input  logic [NB_BANKS-1:0]                             granted_i,
    input  logic [NB_BANKS-1:0][IDX_W-1:0]                  winner_i,
    input  logic [NB_BANKS-1:0][tcdm_pkg::DATA_WIDTH-1:0]   bank_rdata_i,
    output logic [NB_PORTS-1:0]                             rvalid_o,
    output logic [NB_PORTS-1:0][tcdm_pkg::DATA_WIDTH-1:0]   rdata_o
);

    logic [NB_BANKS-1:0]            granted_q;
    logic [NB_BANKS-1:0][IDX_W-1:0] winner_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            granted_q <= '0;
        end else begin
            granted_q <= granted_i;
        end
    end

    always_ff @(posedge clk_i) begin
        winner_q <= winner_i;
    end

    // Each bank serves at most one port, so no two banks collide here
    always_comb begin
        rvalid_o = '0;
        rdata_o  = '0;
        for (int unsigned b = 0; b < NB_BANKS; b++) begin
            if (granted_q[b]) begin
                rvalid_o[winner_q[b]] = 1'b1;
                rdata_o[winner_q[b]]  = bank_rdata_i[b];
            end
        end
    end

endmodule

// ==== tests/tcdm_atomic_xbar_props.sv ====
module tcdm_atomic_xbar_props #(
    parameter int unsigned NB_PORTS = 4,
    parameter int unsigned NB_BANKS = 2
) (
    input logic                                clk_i,
    input logic                                rst_i,
    input logic [NB_PORTS-1:0]                 req_i,
    input tcdm_pkg::port_req_t [NB_PORTS-1:0]  port_req_i,
    input logic [NB_PORTS-1:0]                 gnt_o,
    input logic [NB_PORTS-1:0]                 rvalid_o,
    input logic [NB_BANKS-1:0]                 bank_valid,
    input tcdm_pkg::bank_req_t [NB_BANKS-1:0]  win_req
);

    import tcdm_pkg::*;

    localparam int unsigned BYTE_OFF   = $clog2(BE_WIDTH);
    localparam int unsigned BANK_IDX_W = $clog2(NB_BANKS);

    logic [NB_BANKS-1:0][NB_PORTS-1:0] gnt_by_bank;

    // Port grants sorted by the bank that each port addresses
    always_comb begin
        logic [BANK_IDX_W-1:0] bank;
        gnt_by_bank = '0;
        for (int p = 0; p < NB_PORTS; p++) begin
            bank = port_req_i[p].addr[BYTE_OFF +: BANK_IDX_W];
            gnt_by_bank[bank][p] = gnt_o[p];
        end
    end

    gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        (gnt_o & ~req_i) == '0)
        else $error("grant without request");

    rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_o == $past(gnt_o))
        else $error("response not one cycle after grant");

    for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
        one_winner: assert property (@(posedge clk_i) disable iff (rst_i)
            $onehot0(gnt_by_bank[b]))
            else $error("bank %0d granted more than one port", b);

        // Writeback cycle of an atomic blocks the bank
        amo_stall: assert property (@(posedge clk_i) disable iff (rst_i)
            (bank_valid[b] && win_req[b].amo != AMO_NONE) |=> !bank_valid[b])
            else $error("bank %0d granted during atomic writeback", b);
    end

endmodule

bind tcdm_atomic_xbar tcdm_atomic_xbar_props #(
    .NB_PORTS (NB_PORTS),
    .NB_BANKS (NB_BANKS)
) i_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .port_req_i (port_req_i),
    .gnt_o      (gnt_o),
    .rvalid_o   (rvalid_o),
    .bank_valid (bank_valid),
    .win_req    (win_req)
);

// ==== tests/tcdm_atomic_xbar_tb.sv ====
module tcdm_atomic_xbar_tb;

    import tcdm_pkg::*;

    localparam int unsigned NB_PORTS = 4;
    localparam int unsigned NB_BANKS = 2;
    localparam int unsigned NB_WORDS = NB_BANKS << BANK_ADDR_WIDTH;

    // One row of the stimulus table, ports outside mask stay idle
    typedef struct packed {
        logic [NB_PORTS-1:0]       mask;
        logic [NB_PORTS-1:0][31:0] addr;
        logic [NB_PORTS-1:0][5:0]  atop;
        logic [NB_PORTS-1:0]       wen_n;
        logic [NB_PORTS-1:0][31:0] wdata;
        logic [NB_PORTS-1:0][3:0]  be;
        logic                      chk;
    } entry_t;

    logic                                  clk_i;
    logic                                  rst_i;
    logic [NB_PORTS-1:0]                   req_i;
    port_req_t [NB_PORTS-1:0]              port_req_i;
    logic [NB_PORTS-1:0]                   gnt_o;
    logic [NB_PORTS-1:0]                   rvalid_o;
    logic [NB_PORTS-1:0][DATA_WIDTH-1:0]   rdata_o;
    logic [NB_BANKS-1:0]                   sram_req_o;
    sram_req_t [NB_BANKS-1:0]              sram_o;
    logic [NB_BANKS-1:0][DATA_WIDTH-1:0]   sram_rdata_i;

    logic [31:0] mem [NB_BANKS][1 << BANK_ADDR_WIDTH];
    logic [31:0] ref_mem [NB_WORDS];
    logic [NB_BANKS-1:0][31:0] rd_q;
    logic [31:0] lfsr = 32'hf12f;
    entry_t      table_q[$];
    int          errors = 0;
    int          failed_tests = 0;
    int          cycles = 0;
    int          limit = 0;

    tcdm_atomic_xbar #(
        .NB_PORTS (NB_PORTS),
        .NB_BANKS (NB_BANKS)
    ) tcdm_atomic_xbar_i (.*);

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // SRAM banks with one cycle of read latency
    assign sram_rdata_i = rd_q;
    always @(posedge clk_i) begin
        for (int b = 0; b < NB_BANKS; b++) begin
            if (sram_req_o[b]) begin
                rd_q[b] <= mem[b][sram_o[b].addr];
                if (sram_o[b].we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (sram_o[b].be[k]) begin
                            mem[b][sram_o[b].addr][8*k +: 8] <= sram_o[b].wdata[8*k +: 8];
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, a request was never completed", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Reference memory access, returns the word before the access
    function automatic logic [31:0] ref_access(input logic [31:0] addr, input logic [5:0] atop,
                                               input logic wen_n, input logic [31:0] wdata,
                                               input logic [3:0] be);
        logic [10:0] w;
        logic [31:0] old;
        logic [31:0] nv;
        w   = addr[12:2];
        old = ref_mem[w];
        nv  = old;
        if (atop[5]) begin
            case (atop[4:0])
                5'b00000: nv = old + wdata;
                5'b00001: nv = wdata;
                5'b00100: nv = old ^ wdata;
                5'b01000: nv = old | wdata;
                5'b01100: nv = old & wdata;
                5'b10000: nv = ($signed(old) < $signed(wdata)) ? old : wdata;
                5'b10100: nv = ($signed(old) > $signed(wdata)) ? old : wdata;
                5'b11000: nv = (old < wdata) ? old : wdata;
                5'b11100: nv = (old > wdata) ? old : wdata;
                default:  nv = old;
            endcase
        end else if (!wen_n) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) nv[8*k +: 8] = wdata[8*k +: 8];
            end
        end
        ref_mem[w] = nv;
        return old;
    endfunction

    function automatic entry_t single(input int p, input logic [31:0] addr,
                                      input logic [5:0] atop, input logic wen_n,
                                      input logic [31:0] wdata, input logic [3:0] be);
        entry_t e;
        e          = '0;
        e.mask[p]  = 1'b1;
        e.addr[p]  = addr;
        e.atop[p]  = atop;
        e.wen_n[p] = wen_n;
        e.wdata[p] = wdata;
        e.be[p]    = be;
        e.chk      = wen_n | atop[5];
        return e;
    endfunction

    task automatic drive(input entry_t e, input logic [NB_PORTS-1:0] pending);
        req_i = pending;
        for (int p = 0; p < NB_PORTS; p++) begin
            port_req_i[p].addr  = e.addr[p];
            port_req_i[p].wdata = e.wdata[p];
            port_req_i[p].wen_n = e.wen_n[p];
            port_req_i[p].be    = e.be[p];
            port_req_i[p].atop  = e.atop[p];
        end
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        logic [NB_PORTS-1:0]       pending;
        logic [NB_PORTS-1:0]       waiting;
        logic [NB_PORTS-1:0][31:0] exp;
        int                        errs_before;
        pending     = e.mask;
        waiting     = '0;
        exp         = '0;
        errs_before = errors;
        drive(e, pending);
        while (pending != '0 || waiting != '0) begin
            @(negedge clk_i);
            for (int p = 0; p < NB_PORTS; p++) begin
                if (waiting[p]) begin
                    if (!rvalid_o[p]) begin
                        $display("test %0d: port %0d got no response one cycle after its grant",
                                 idx, p);
                        errors++;
                    end else if (e.chk && rdata_o[p] !== exp[p]) begin
                        $display("error at %0t: rdata_o[%0d] expected %h actual %h",
                                 $time, p, exp[p], rdata_o[p]);
                        errors++;
                    end
                end
            end
            waiting = '0;
            // Grants within a cycle go to different banks, so order does not matter
            for (int p = 0; p < NB_PORTS; p++) begin
                if (pending[p] && gnt_o[p]) begin
                    exp[p]     = ref_access(e.addr[p], e.atop[p], e.wen_n[p], e.wdata[p], e.be[p]);
                    waiting[p] = 1'b1;
                    pending[p] = 1'b0;
                end
            end
            @(posedge clk_i);
            #10;
            drive(e, pending);
        end
        if (errors == errs_before) begin
            $display("test %0d passed", idx);
        end else begin
            $display("test %0d failed", idx);
            failed_tests++;
        end
    endtask

    initial begin
        logic [4:0]  ops [9];
        logic [31:0] v;
        logic [31:0] a;
        logic [31:0] operand;
        entry_t      e;
        req_i      = '0;
        port_req_i = '0;
        rd_q       = '0;
        rst_i      = 1'b1;
        for (int w = 0; w < NB_WORDS; w++) begin
            v = rand_bits(32);
            mem[w % NB_BANKS][w / NB_BANKS] = v;
            ref_mem[w] = v;
        end
        ops = '{5'b00000, 5'b00001, 5'b00100, 5'b01000, 5'b01100,
                5'b10000, 5'b10100, 5'b11000, 5'b11100};

        // Write then read back on every port, then reads of two banks
        e = '0;
        for (int p = 0; p < NB_PORTS; p++) e = e | single(p, 32'h100 + 4*p, 6'h0, 1'b0,
                                                           rand_bits(32), 4'hf);
        table_q.push_back(e);
        e = '0;
        for (int p = 0; p < NB_PORTS; p++) e = e | single(p, 32'h100 + 4*p, 6'h0, 1'b1,
                                                           32'h0, 4'h0);
        table_q.push_back(e);
        table_q.push_back(single(0, 32'h200, 6'h0, 1'b1, 32'h0, 4'h0) |
                          single(1, 32'h204, 6'h0, 1'b1, 32'h0, 4'h0));

        // Each atomic, with a negative old word for the compare operations
        for (int k = 0; k < 9; k++) begin
            a = 32'h300 + 4*k;
            operand = rand_bits(32);
            if (k >= 5) begin
                table_q.push_back(single(0, a, 6'h0, 1'b0, 32'h8000_1234, 4'hf));
                operand = 32'h10;
            end
            table_q.push_back(single(k % 4, a, {1'b1, ops[k]}, 1'b0, operand, 4'hf));
            table_q.push_back(single((k + 1) % 4, a, 6'h0, 1'b1, 32'h0, 4'h0));
        end

        // Two ports add to the same word at once
        table_q.push_back(single(0, 32'h400, 6'h20, 1'b0, rand_bits(32), 4'hf) |
                          single(2, 32'h400, 6'h20, 1'b0, rand_bits(32), 4'hf));
        table_q.push_back(single(1, 32'h400, 6'h0, 1'b1, 32'h0, 4'h0));

        // Four reads spread over both banks
        table_q.push_back(single(0, 32'h500, 6'h0, 1'b1, 32'h0, 4'h0) |
                          single(1, 32'h504, 6'h0, 1'b1, 32'h0, 4'h0) |
                          single(2, 32'h50c, 6'h0, 1'b1, 32'h0, 4'h0) |
                          single(3, 32'h518, 6'h0, 1'b1, 32'h0, 4'h0));

        // Partial byte enables
        table_q.push_back(single(0, 32'h600, 6'h0, 1'b0, rand_bits(32), 4'hf));
        table_q.push_back(single(1, 32'h600, 6'h0, 1'b0, rand_bits(32), 4'b0101));
        table_q.push_back(single(2, 32'h600, 6'h0, 1'b1, 32'h0, 4'h0));

        limit = table_q.size() * 8 + 4;
        repeat (4) @(posedge clk_i);
        #10;
        rst_i = 1'b0;
        foreach (table_q[i]) run_entry(i, table_q[i]);

        $display("%0d tests run, %0d failed, %0d errors", table_q.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
